// ==== Makefile ====
# Verilator flow for the execute stage

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module exu_top -f exu.f
	verilator --lint-only --timing --timescale 1ns/1ps --top-module tb_exu -f exu.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_exu \
		-f exu.f -Mdir obj_dir
	./obj_dir/Vtb_exu

clean:
	rm -rf obj_dir

// ==== exu.f ====
rtl/exu_pkg.sv
rtl/intu_of_if.sv
rtl/intu_opf.sv
rtl/intu_alu.sv
rtl/intu_msr.sv
rtl/exu_top.sv
tests/tb_exu.sv

// ==== rtl/exu_pkg.sv ====
/*
 Shared definitions for the execute stage
 Major opcode and result-source enums, datapath widths,
 MSR bit positions and break ra codes
*/
`default_nettype none

package exu_pkg;

   localparam int data_w   = 32;   // Datapath width
   localparam int addr_lsb = 2;    // Word addresses drop the byte bits

   // Major opcodes, octal as in the ISA manual
   // Immediate form of a group differs only in bit 3
   typedef enum logic [5:0] {
      op_add    = 6'o00,
      op_rsub   = 6'o01,
      op_addc   = 6'o02,
      op_rsubc  = 6'o03,
      op_addk   = 6'o04,
      op_rsubk  = 6'o05,   // Also cmp/cmpu, picked by imm[1:0]
      op_addi   = 6'o10,
      op_rsubi  = 6'o11,
      op_addic  = 6'o12,
      op_rsubic = 6'o13,
      op_addik  = 6'o14,
      op_rsubik = 6'o15,
      op_or     = 6'o40,
      op_and    = 6'o41,
      op_xor    = 6'o42,
      op_andn   = 6'o43,
      op_shift  = 6'o44,   // sra, src, srl, sext8, sext16
      op_mov    = 6'o45,   // mts, msrset, msrclr
      op_br     = 6'o46,   // Branch, brk when ra is 5'hC
      op_bcc    = 6'o47,
      op_ori    = 6'o50,
      op_andi   = 6'o51,
      op_xori   = 6'o52,
      op_andni  = 6'o53,
      op_rtd    = 6'o55,   // rtsd, rtid, rtbd by rd bits
      op_bri    = 6'o56,   // Branch imm, brki on ra 5'hC/5'hD
      op_bcci   = 6'o57
   } opcode_e;

   // Where the stage result would come from
   typedef enum logic [2:0] {
      mux_nop = 3'o0,
      mux_alu = 3'o1,
      mux_rpc = 3'o2,   // Link PC, supplied by fetch
      mux_mem = 3'o4,
      mux_sfr = 3'o7    // Special register readback
   } mux_e;

   // MSR bit positions
   localparam int msr_be  = 0;    // Bus lock enable
   localparam int msr_ie  = 1;    // Interrupt enable
   localparam int msr_c   = 2;    // Carry
   localparam int msr_bip = 3;    // Break in progress
   localparam int msr_mtx = 4;    // Mutex
   localparam int msr_ite = 5;    // I-cache enable
   localparam int msr_dte = 7;    // D-cache enable
   localparam int msr_cc  = 31;   // Carry copy, readback image only

   // ra codes of the break forms
   localparam logic [4:0] brk_ra_int = 5'hD;
   localparam logic [4:0] brk_ra_brk = 5'hC;

endpackage

`default_nettype wire

// ==== rtl/exu_top.sv ====
/*
 Execute stage top level
 Operand stage, integer unit and MSR unit behind plain ports
*/
`default_nettype none

module exu_top (
   input  logic                                        gclk,
   input  logic                                        grst,
   input  logic                                        dena,
   input  exu_pkg::opcode_e                            opc,
   input  logic [exu_pkg::data_w-1:0]                  rega,
   input  logic [exu_pkg::data_w-1:0]                  regb,
   input  logic [exu_pkg::data_w-1:0]                  regd,
   input  logic [15:0]                                 imm,
   input  logic [4:0]                                  rd,
   input  logic [4:0]                                  ra,
   output logic [exu_pkg::data_w-1:0]                  alu_ex,
   output logic [exu_pkg::data_w-1:0]                  alu_mx,
   output logic [exu_pkg::data_w-1:exu_pkg::addr_lsb]  mem_ex,
   output logic [exu_pkg::data_w-1:exu_pkg::addr_lsb]  bpc_ex,
   output logic [7:0]                                  msr_ex,
   output logic [exu_pkg::data_w-1:0]                  sfr_mx
);

   logic carry_cc;    // MSR carry copy into the adder
   logic add_carry;   // Adder carry out into the MSR

   intu_of_if ofb ();   // Registered operands

   intu_opf u_opf (
      .gclk (gclk),
      .grst (grst),
      .dena (dena),
      .opc  (opc),
      .rega (rega),
      .regb (regb),
      .regd (regd),
      .imm  (imm),
      .rd   (rd),
      .ra   (ra),
      .ofb  (ofb.src)
   );

   intu_alu u_alu (
      .gclk      (gclk),
      .grst      (grst),
      .dena      (dena),
      .ofb       (ofb.alu),
      .carry_cc  (carry_cc),
      .add_carry (add_carry),
      .alu_ex    (alu_ex),
      .alu_mx    (alu_mx),
      .mem_ex    (mem_ex),
      .bpc_ex    (bpc_ex)
   );

   intu_msr u_msr (
      .gclk      (gclk),
      .grst      (grst),
      .dena      (dena),
      .ofb       (ofb.msr),
      .add_carry (add_carry),
      .carry_cc  (carry_cc),
      .msr_ex    (msr_ex),
      .sfr_mx    (sfr_mx)
   );

endmodule

`default_nettype wire

// ==== rtl/intu_alu.sv ====
/*
 Integer unit datapath
 Add/subtract/compare with carry, shift-logic-move path,
 load/store address, branch target and the result pipeline
*/
`default_nettype none

module intu_alu (
   input  logic                                        gclk,
   input  logic                                        grst,
   input  logic                                        dena,
   intu_of_if.alu                                      ofb,
   input  logic                                        carry_cc,
   output logic                                        add_carry,
   output logic [exu_pkg::data_w-1:0]                  alu_ex,
   output logic [exu_pkg::data_w-1:0]                  alu_mx,
   output logic [exu_pkg::data_w-1:exu_pkg::addr_lsb]  mem_ex,
   output logic [exu_pkg::data_w-1:exu_pkg::addr_lsb]  bpc_ex
);
   import exu_pkg::*;

   logic              f_sub;     // rsub forms invert opa
   logic              f_ccc;     // Carry forms take carry copy
   logic              f_cmp;     // cmp/cmpu
   logic              f_cmpu;    // Unsigned compare
   logic              f_abs;     // Absolute branch
   logic              add_cin;
   logic              cmp_gt;
   logic [data_w-1:0] opa_x;
   logic [data_w-1:0] add_sum;
   logic [data_w-1:0] add_res;
   logic [data_w-1:0] slm_res;
   logic [data_w-1:0] res_nxt;
   logic [2:0]        shf_sel;   // {imm[6:5], imm[0]}
   mux_e              res_mux;

   // Adder controls, only the add/sub groups (bit 5 clear)
   assign f_sub  = !ofb.opc[5] & ofb.opc[0];
   assign f_ccc  = !ofb.opc[5] & ofb.opc[1];
   assign f_cmp  = (ofb.opc == op_rsubk) & ofb.imm[0];
   assign f_cmpu = ofb.imm[1];
   assign f_abs  = ((ofb.opc == op_br) | (ofb.opc == op_bri)) & ofb.ra[3];   // A bit

   assign opa_x   = f_sub ? ~ofb.opa : ofb.opa;   // rb - ra as rb + ~ra + 1
   assign add_cin = f_ccc ? carry_cc : f_sub;

   // One adder with carry out, shared by sum, address and target
   assign {add_carry, add_sum} = {1'b0, ofb.opb} + {1'b0, opa_x}
                                 + {{data_w{1'b0}}, add_cin};

   assign cmp_gt = f_cmpu ? (ofb.opa > ofb.opb)
                          : ($signed(ofb.opa) > $signed(ofb.opb));

   // cmp puts the greater-than flag in the sign bit
   assign add_res = {(f_cmp ? cmp_gt : add_sum[data_w-1]), add_sum[data_w-2:0]};

   assign shf_sel = {ofb.imm[6:5], ofb.imm[0]};

   // Shift, logic, move path
   always_comb begin
      case (ofb.opc[2:0])
         3'o0: slm_res = ofb.opa | ofb.opb;    // or
         3'o1: slm_res = ofb.opa & ofb.opb;    // and
         3'o2: slm_res = ofb.opa ^ ofb.opb;    // xor
         3'o3: slm_res = ofb.opa & ~ofb.opb;   // andn
         3'o4: begin
            case (shf_sel)
               3'o1: slm_res = {ofb.opa[data_w-1], ofb.opa[data_w-1:1]};  // sra
               3'o3: slm_res = {carry_cc, ofb.opa[data_w-1:1]};          // src
               3'o5: slm_res = {1'b0, ofb.opa[data_w-1:1]};              // srl
               3'o6: slm_res = {{(data_w-8){ofb.opa[7]}}, ofb.opa[7:0]};  // sext8
               3'o7: slm_res = {{(data_w-16){ofb.opa[15]}}, ofb.opa[15:0]};
               default: slm_res = '0;
            endcase
         end
         default: slm_res = '0;   // Move, branch, return give nothing here
      endcase
   end

   // Result source, only the alu class is produced in this stage
   always_comb begin
      if (!ofb.opc[5] || (ofb.opc[2:0] < 3'o5)) begin
         res_mux = mux_alu;
      end else if (ofb.opc == op_mov) begin
         res_mux = mux_sfr;   // MSR readback path
      end else begin
         res_mux = mux_rpc;   // Branch/return link from fetch
      end
   end

   always_comb begin
      if (res_mux == mux_alu) begin
         res_nxt = ofb.opc[5] ? slm_res : add_res;
      end else begin
         res_nxt = '0;
      end
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         alu_ex <= '0;
         alu_mx <= '0;
         mem_ex <= '0;
         bpc_ex <= '0;
      end else if (dena) begin
         alu_mx <= alu_ex;   // One more stage for writeback
         alu_ex <= res_nxt;
         mem_ex <= add_sum[data_w-1:addr_lsb];   // ra + rb / ra + imm
         bpc_ex <= f_abs ? ofb.opb[data_w-1:addr_lsb]
                         : add_sum[data_w-1:addr_lsb];   // PC-relative and rtd
      end
   end

   // Operand stage must never pass an undefined shift selector
   a_shf_sel: assert property (@(posedge gclk) disable iff (grst)
      (ofb.opc == op_shift) |-> (shf_sel inside {3'o1, 3'o3, 3'o5, 3'o6, 3'o7}))
      else $error("intu_alu: undefined shift selector %o", shf_sel);

endmodule

`default_nettype wire

// ==== rtl/intu_msr.sv ====
/*
 Machine status register
 Carry and carry copy, mts and msrset/msrclr, break and return toggles,
 special register readback pipe
*/
`default_nettype none

module intu_msr (
   input  logic                       gclk,
   input  logic                       grst,
   input  logic                       dena,
   intu_of_if.msr                     ofb,
   input  logic                       add_carry,
   output logic                       carry_cc,
   output logic [7:0]                 msr_ex,
   output logic [exu_pkg::data_w-1:0] sfr_mx
);
   import exu_pkg::*;

   logic              be_q, ie_q, c_q, bip_q;
   logic              mtx_q, ite_q, dte_q;
   logic              cc_q;        // Carry copy
   logic              f_mov, f_mts, f_mop, f_mv;
   logic              f_brk, f_brkb, f_brki;
   logic              f_rtbd, f_rtid;
   logic              f_shift, f_addsub;
   logic [7:0]        mop_res;     // msrset/msrclr result
   logic [7:0]        mv_val;      // New MSR byte on a move
   logic [data_w-1:0] sfr_img;
   logic [data_w-1:0] sfr_ex;

   assign carry_cc = cc_q;

   // Visible MSR byte, bit 6 reads zero
   always_comb begin
      msr_ex          = '0;
      msr_ex[msr_be]  = be_q;
      msr_ex[msr_ie]  = ie_q;
      msr_ex[msr_c]   = c_q;
      msr_ex[msr_bip] = bip_q;
      msr_ex[msr_mtx] = mtx_q;
      msr_ex[msr_ite] = ite_q;
      msr_ex[msr_dte] = dte_q;
   end

   // Move group, imm[15:14] 11 for mts, 00 for set/clear
   assign f_mov = (ofb.opc == op_mov);
   assign f_mts = f_mov & (&ofb.imm[15:14]);
   assign f_mop = f_mov & ~|ofb.imm[15:14];
   assign f_mv  = f_mts | f_mop;

   assign mop_res = ofb.ra[0] ? (msr_ex & ~ofb.imm[7:0])   // msrclr
                              : (msr_ex | ofb.imm[7:0]);   // msrset
   assign mv_val  = f_mts ? ofb.opa[7:0] : mop_res;

   // Breaks share the branch opcodes, ra picks the kind
   assign f_brk  = (ofb.opc == op_br) | (ofb.opc == op_bri);
   assign f_brkb = f_brk & (ofb.ra == brk_ra_brk);
   assign f_brki = f_brk & (ofb.ra == brk_ra_int);
   assign f_rtid = (ofb.opc == op_rtd) & ofb.rd[0];
   assign f_rtbd = (ofb.opc == op_rtd) & ofb.rd[1];

   // Carry writers, sext leaves carry alone
   assign f_shift  = (ofb.opc == op_shift) & (ofb.imm[6:5] != 2'b11);
   assign f_addsub = (ofb.opc[5:2] == 4'h0) | (ofb.opc[5:2] == 4'h2);   // Not the k forms

   // Readback image, carry copy on top
   always_comb begin
      sfr_img         = '0;
      sfr_img[7:0]    = msr_ex;
      sfr_img[msr_cc] = cc_q;
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         be_q   <= 1'b0;
         ie_q   <= 1'b0;
         bip_q  <= 1'b0;
         mtx_q  <= 1'b0;
         ite_q  <= 1'b0;
         dte_q  <= 1'b0;
         c_q    <= 1'b0;
         cc_q   <= 1'b0;
         sfr_ex <= '0;
         sfr_mx <= '0;
      end else if (dena) begin
         if (f_mv) begin
            be_q  <= mv_val[msr_be];
            ie_q  <= mv_val[msr_ie];
            bip_q <= mv_val[msr_bip];
            mtx_q <= mv_val[msr_mtx];
            ite_q <= mv_val[msr_ite];
            dte_q <= mv_val[msr_dte];
         end else begin
            if (f_brkb | f_rtbd) begin
               bip_q <= !bip_q;   // Enter or leave break
            end
            if (f_brki | f_rtid) begin
               ie_q <= !ie_q;
            end
         end

         cc_q <= c_q;   // Copy trails carry by one cycle
         if (f_mv) begin
            c_q <= mv_val[msr_c];
         end else if (f_shift) begin
            c_q <= ofb.opa[0];   // Bit shifted out
         end else if (f_addsub) begin
            c_q <= add_carry;
         end else begin
            c_q <= cc_q;
         end

         sfr_ex <= sfr_img;
         sfr_mx <= sfr_ex;
      end
   end

   // Every move decodes as exactly one of mts or set/clear
   a_mov_form: assert property (@(posedge gclk) disable iff (grst)
      f_mov |-> (f_mts ^ f_mop))
      else $error("intu_msr: undefined move form, imm %h", ofb.imm);

endmodule

`default_nettype wire

// ==== rtl/intu_of_if.sv ====
/*
 Registered operand bundle
 Driven by the operand stage, read by the integer unit and the MSR unit
*/
`default_nettype none

interface intu_of_if;
   import exu_pkg::*;

   opcode_e           opc;   // Registered major opcode
   logic [data_w-1:0] opa;   // ra register value
   logic [data_w-1:0] opb;   // rb value or extended imm
   logic [data_w-1:0] opd;   // rd register value, store data
   logic [15:0]       imm;   // Raw immediate, also function bits
   logic [4:0]        rd;
   logic [4:0]        ra;

   // Operand stage owns every field
   modport src (
      output opc, opa, opb, opd, imm, rd, ra
   );

   // Adder, shift/logic, address paths
   modport alu (
      input opc, opa, opb, imm, ra
   );

   // Status register updates
   modport msr (
      input opc, opa, imm, rd, ra
   );

endinterface

`default_nettype wire

// ==== rtl/intu_opf.sv ====
/*
 Operand stage of the integer unit
 Registers decoded fields, picks rb or sign-extended imm as operand b
*/
`default_nettype none

module intu_opf (
   input  logic                       gclk,
   input  logic                       grst,
   input  logic                       dena,
   input  exu_pkg::opcode_e           opc,
   input  logic [exu_pkg::data_w-1:0] rega,
   input  logic [exu_pkg::data_w-1:0] regb,
   input  logic [exu_pkg::data_w-1:0] regd,
   input  logic [15:0]                imm,
   input  logic [4:0]                 rd,
   input  logic [4:0]                 ra,
   intu_of_if.src                     ofb
);
   import exu_pkg::*;

   logic [data_w-1:0] imm_sx;   // imm extended to full width

   assign imm_sx = {{(data_w-16){imm[15]}}, imm};

   always_ff @(posedge gclk) begin
      if (grst) begin
         ofb.opc <= op_or;   // Harmless opcode, touches no MSR state
         ofb.opa <= '0;
         ofb.opb <= '0;
         ofb.opd <= '0;
         ofb.imm <= '0;
         ofb.rd  <= '0;
         ofb.ra  <= '0;
      end else if (dena) begin
         ofb.opc <= opc;
         ofb.opa <= rega;
         // Bit 3 marks the immediate form of every group
         ofb.opb <= opc[3] ? imm_sx : regb;
         ofb.opd <= regd;
         ofb.imm <= imm;
         ofb.rd  <= rd;
         ofb.ra  <= ra;
      end
   end

   // Downstream decoders assume one of the known major opcodes
   a_opc_known: assert property (@(posedge gclk) disable iff (grst)
      ofb.opc inside {[6'o00:6'o05], [6'o10:6'o15], [6'o40:6'o47],
                      [6'o50:6'o53], [6'o55:6'o57]})
      else $error("intu_opf: undefined opcode %o", ofb.opc);

endmodule

`default_nettype wire

// ==== tests/tb_exu.sv ====
/*
 Testbench for the execute stage top level
 Instruction table with LFSR operands, reference model of the datapath and MSR,
 typed compare tasks and a cycle limit
*/
`default_nettype none

module tb_exu;
   timeunit 1ns;
   timeprecision 1ps;
   import exu_pkg::*;

   typedef struct {
      opcode_e     opc;
      logic [31:0] a;     // rega
      logic [31:0] b;     // regb
      logic [15:0] imm;
      logic [4:0]  rd;
      logic [4:0]  ra;
      logic        en;    // dena for this row
      logic [1:0]  rnd;   // Bit 0 draws rega, bit 1 draws regb
   } row_t;

   logic gclk = 1'b0;
   logic grst;
   logic dena;
   opcode_e opc;
   logic [data_w-1:0] rega, regb, regd;
   logic [15:0] imm;
   logic [4:0] rd, ra;
   logic [data_w-1:0] alu_ex, alu_mx, sfr_mx;
   logic [data_w-1:addr_lsb] mem_ex, bpc_ex;
   logic [7:0] msr_ex;

   row_t rows[$];
   int cyc_cnt = 0;
   logic [15:0] lfsr_q = 16'd37581;

   // Model state, starts at the reset values
   opcode_e m_opc = op_or;
   logic [data_w-1:0] m_opa = '0, m_opb = '0;
   logic [15:0] m_imm = '0;
   logic [4:0] m_rd = '0, m_ra = '0;
   logic [data_w-1:0] m_alu_ex = '0, m_alu_mx = '0;
   logic [data_w-1:0] m_sfr_ex = '0, m_sfr_mx = '0;
   logic [data_w-1:addr_lsb] m_mem_ex = '0, m_bpc_ex = '0;
   logic [7:0] m_msr = '0;
   logic m_cc = 1'b0;   // Carry copy

   exu_top dut_i (
      .gclk(gclk), .grst(grst), .dena(dena), .opc(opc),
      .rega(rega), .regb(regb), .regd(regd), .imm(imm), .rd(rd), .ra(ra),
      .alu_ex(alu_ex), .alu_mx(alu_mx), .mem_ex(mem_ex), .bpc_ex(bpc_ex),
      .msr_ex(msr_ex), .sfr_mx(sfr_mx)
   );

   initial begin
      forever #20 gclk = ~gclk;   // 40 ns period
   end

   // 16-bit Fibonacci LFSR, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [31:0] draw_word();
      logic [31:0] w;
      w = '0;
      for (int k = 0; k < 32; k++) begin
         lfsr_q = lfsr_next(lfsr_q);   // One step per bit
         w = {w[30:0], lfsr_q[0]};
      end
      return w;
   endfunction

   task automatic add_row(input opcode_e o, input logic [31:0] a, input logic [31:0] b,
                          input logic [15:0] i, input logic [4:0] d, input logic [4:0] s,
                          input logic en, input logic [1:0] rnd);
      row_t r;
      r.opc = o;
      r.a   = a;
      r.b   = b;
      r.imm = i;
      r.rd  = d;
      r.ra  = s;
      r.en  = en;
      r.rnd = rnd;
      rows.push_back(r);
   endtask

   // Reference model, one dena cycle of the two registered stages
   task automatic model_step(input row_t r);
      logic        sub;
      logic        use_cc;
      logic        cin;
      logic        gt;
      logic        mv;
      logic        brk;
      logic [2:0]  sel;
      logic [7:0]  mval;
      logic [7:0]  nmsr;
      logic [32:0] sum;
      logic [31:0] res;
      if (!r.en) return;   // Stage frozen
      sub    = m_opc inside {op_rsub, op_rsubc, op_rsubk, op_rsubi, op_rsubic, op_rsubik};
      use_cc = m_opc inside {op_addc, op_rsubc, op_addic, op_rsubic};
      cin    = use_cc ? m_cc : sub;   // rsub is rb + ~ra + 1
      sum    = {1'b0, m_opb} + {1'b0, (sub ? ~m_opa : m_opa)} + {32'b0, cin};
      gt     = m_imm[1] ? (m_opa > m_opb) : ($signed(m_opa) > $signed(m_opb));
      sel    = {m_imm[6:5], m_imm[0]};
      case (m_opc)
         op_or, op_ori:     res = m_opa | m_opb;
         op_and, op_andi:   res = m_opa & m_opb;
         op_xor, op_xori:   res = m_opa ^ m_opb;
         op_andn, op_andni: res = m_opa & ~m_opb;
         op_shift: begin
            case (sel)
               3'b001:  res = {m_opa[31], m_opa[31:1]};            // sra
               3'b011:  res = {m_cc, m_opa[31:1]};                 // src
               3'b101:  res = {1'b0, m_opa[31:1]};                 // srl
               3'b110:  res = {{24{m_opa[7]}}, m_opa[7:0]};        // sext8
               default: res = {{16{m_opa[15]}}, m_opa[15:0]};      // sext16
            endcase
         end
         op_mov, op_br, op_bcc, op_rtd, op_bri, op_bcci: res = '0;   // Not an alu result
         default: res = (m_opc == op_rsubk && m_imm[0]) ? {gt, sum[30:0]} : sum[31:0];
      endcase

      // MSR byte, moves win over toggles and carry writers
      mv   = (m_opc == op_mov) && (m_imm[15:14] == 2'b11 || m_imm[15:14] == 2'b00);
      mval = (m_imm[15:14] == 2'b11) ? m_opa[7:0]
           : (m_ra[0] ? (m_msr & ~m_imm[7:0]) : (m_msr | m_imm[7:0]));
      brk  = m_opc inside {op_br, op_bri};
      nmsr = m_msr;
      if (mv) begin
         nmsr = mval & 8'hBF;   // Bit 6 not implemented
      end else begin
         if ((brk && m_ra == brk_ra_brk) || (m_opc == op_rtd && m_rd[1]))
            nmsr[msr_bip] = ~nmsr[msr_bip];
         if ((brk && m_ra == brk_ra_int) || (m_opc == op_rtd && m_rd[0]))
            nmsr[msr_ie] = ~nmsr[msr_ie];
         if (m_opc == op_shift && m_imm[6:5] != 2'b11)
            nmsr[msr_c] = m_opa[0];
         else if (m_opc inside {op_add, op_rsub, op_addc, op_rsubc,
                                op_addi, op_rsubi, op_addic, op_rsubic})
            nmsr[msr_c] = sum[32];
         else
            nmsr[msr_c] = m_cc;   // Carry reloads from its copy
      end

      m_sfr_mx = m_sfr_ex;
      m_sfr_ex = {m_cc, 23'b0, m_msr};   // Image before this update
      m_cc     = m_msr[msr_c];
      m_msr    = nmsr;
      m_alu_mx = m_alu_ex;
      m_alu_ex = res;
      m_mem_ex = sum[data_w-1:addr_lsb];
      m_bpc_ex = (brk && m_ra[3]) ? m_opb[data_w-1:addr_lsb] : sum[data_w-1:addr_lsb];

      // Operand stage takes the new row
      m_opc = r.opc;
      m_opa = r.a;
      m_opb = r.opc[3] ? {{16{r.imm[15]}}, r.imm} : r.b;
      m_imm = r.imm;
      m_rd  = r.rd;
      m_ra  = r.ra;
   endtask

   task automatic check_word(input string what, input logic [data_w-1:0] got,
                             input logic [data_w-1:0] exp);
      if (got !== exp) begin
         $display("error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
         $display("Done: errors found");
         $fatal(1, "data mismatch");
      end
   endtask

   task automatic check_addr(input string what, input logic [data_w-1:addr_lsb] got,
                             input logic [data_w-1:addr_lsb] exp);
      if (got !== exp) begin
         $display("error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
         $display("Done: errors found");
         $fatal(1, "address mismatch");
      end
   endtask

   task automatic check_msr(input string what, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         $display("error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
         $display("Done: errors found");
         $fatal(1, "MSR mismatch");
      end
   endtask

   task automatic check_outputs();
      check_word("alu_ex", alu_ex, m_alu_ex);
      check_word("alu_mx", alu_mx, m_alu_mx);
      check_addr("mem_ex", mem_ex, m_mem_ex);
      check_addr("bpc_ex", bpc_ex, m_bpc_ex);
      check_msr("msr_ex", msr_ex, m_msr);
      check_word("sfr_mx", sfr_mx, m_sfr_mx);
   endtask

   task automatic build_table();
      // Add, subtract, compare, carry chain
      // First row has ra bit 3 set, which only branches treat as absolute
      add_row(op_add,    32'h0000_0005, 32'h0000_0007, 16'h0000, 5'd3, 5'd9, 1'b1, 2'd0);
      add_row(op_add,    32'hFFFF_FFFF, 32'h0000_0001, 16'h0000, 5'd3, 5'd1, 1'b1, 2'd0);
      add_row(op_addc,   32'h0000_0001, 32'h0000_0002, 16'h0000, 5'd3, 5'd1, 1'b1, 2'd0);
      add_row(op_addc,   32'hFFFF_FFFF, 32'h0000_0000, 16'h0000, 5'd3, 5'd1, 1'b1, 2'd0);
      add_row(op_rsubc,  32'h0000_0003, 32'h0000_000A, 16'h0000, 5'd3, 5'd1, 1'b1, 2'd0);
      add_row(op_rsubc,  32'h0000_000A, 32'h0000_0003, 16'h0000, 5'd3, 5'd1, 1'b1, 2'd0);
      add_row(op_rsub,   32'h0000_0003, 32'h0000_000A, 16'h0000, 5'd3, 5'd1, 1'b1, 2'd0);
      add_row(op_addk,   32'hFFFF_FFFF, 32'h0000_0001, 16'h0000, 5'd3, 5'd1, 1'b1, 2'd0);
      add_row(op_rsubk,  32'h0000_0007, 32'h0000_0002, 16'h0000, 5'd3, 5'd1, 1'b1, 2'd0);
      add_row(op_rsubk,  32'hFFFF_FFFF, 32'h0000_0001, 16'h0001, 5'd3, 5'd1, 1'b1, 2'd0);
      add_row(op_rsubk,  32'hFFFF_FFFF, 32'h0000_0001, 16'h0003, 5'd3, 5'd1, 1'b1, 2'd0);
      add_row(op_addi,   32'h0000_1000, 32'h0000_0000, 16'hFFF0, 5'd4, 5'd2, 1'b1, 2'd0);
      add_row(op_addic,  32'h7FFF_FFFF, 32'h0000_0000, 16'h0001, 5'd4, 5'd2, 1'b1, 2'd0);
      add_row(op_rsubic, 32'h0000_0002, 32'h0000_0000, 16'hFFFF, 5'd4, 5'd2, 1'b1, 2'd0);
      add_row(op_addik,  32'h0000_0100, 32'h0000_0000, 16'h8000, 5'd4, 5'd2, 1'b1, 2'd0);
      add_row(op_add,    32'h0,         32'h0,         16'h0000, 5'd5, 5'd6, 1'b1, 2'd3);
      add_row(op_addc,   32'h0,         32'h0,         16'h0000, 5'd5, 5'd6, 1'b1, 2'd3);
      add_row(op_rsubc,  32'h0,         32'h0,         16'h0000, 5'd5, 5'd6, 1'b1, 2'd3);
      // Logic, one-bit shifts, sign extension
      add_row(op_or,     32'h0,         32'h0,         16'h0000, 5'd7, 5'd2, 1'b1, 2'd3);
      add_row(op_and,    32'h0,         32'h0,         16'h0000, 5'd7, 5'd2, 1'b1, 2'd3);
      add_row(op_xor,    32'h0,         32'h0,         16'h0000, 5'd7, 5'd2, 1'b1, 2'd3);
      add_row(op_andn,   32'h0,         32'h0,         16'h0000, 5'd7, 5'd2, 1'b1, 2'd3);
      add_row(op_ori,    32'h0000_00F0, 32'h0000_0000, 16'h0F0F, 5'd7, 5'd2, 1'b1, 2'd0);
      add_row(op_andni,  32'h0,         32'h0000_0000, 16'h8001, 5'd7, 5'd2, 1'b1, 2'd1);
      add_row(op_shift,  32'h8000_0003, 32'h0000_0000, 16'h0001, 5'd7, 5'd2, 1'b1, 2'd0);
      add_row(op_shift,  32'h0000_0002, 32'h0000_0000, 16'h0021, 5'd7, 5'd2, 1'b1, 2'd0);
      add_row(op_shift,  32'h8000_0001, 32'h0000_0000, 16'h0041, 5'd7, 5'd2, 1'b1, 2'd0);
      add_row(op_shift,  32'h0000_0080, 32'h0000_0000, 16'h0060, 5'd7, 5'd2, 1'b1, 2'd0);
      add_row(op_shift,  32'h1234_8000, 32'h0000_0000, 16'h0061, 5'd7, 5'd2, 1'b1, 2'd0);
      add_row(op_shift,  32'h0,         32'h0000_0000, 16'h0021, 5'd7, 5'd2, 1'b1, 2'd1);
      // Branch targets, relative and absolute
      add_row(op_br,     32'h0000_1000, 32'h0000_0040, 16'h0000, 5'd0, 5'h00, 1'b1, 2'd0);
      add_row(op_br,     32'h0000_1000, 32'h0000_2000, 16'h0000, 5'd0, 5'h08, 1'b1, 2'd0);
      add_row(op_bri,    32'h0000_1000, 32'h0000_0000, 16'hFF00, 5'd0, 5'h08, 1'b1, 2'd0);
      add_row(op_bcci,   32'h0000_0400, 32'h0000_0000, 16'hFFFC, 5'd1, 5'h01, 1'b1, 2'd0);
      // MSR moves
      add_row(op_mov,    32'h0000_00A5, 32'h0000_0000, 16'hC001, 5'd0, 5'd0, 1'b1, 2'd0);
      add_row(op_mov,    32'h0000_0000, 32'h0000_0000, 16'h0012, 5'd0, 5'd0, 1'b1, 2'd0);
      add_row(op_mov,    32'h0000_0000, 32'h0000_0000, 16'h0081, 5'd0, 5'd1, 1'b1, 2'd0);
      // Break and return toggles
      add_row(op_br,     32'h0000_0000, 32'h0000_0010, 16'h0000, 5'd16, 5'hC, 1'b1, 2'd0);
      add_row(op_bri,    32'h0000_0000, 32'h0000_0000, 16'h0010, 5'd17, 5'hD, 1'b1, 2'd0);
      add_row(op_rtd,    32'h0000_0100, 32'h0000_0000, 16'h0008, 5'd2, 5'd1, 1'b1, 2'd0);
      add_row(op_rtd,    32'h0000_0200, 32'h0000_0000, 16'h0008, 5'd1, 5'd1, 1'b1, 2'd0);
      // dena low, stage frozen
      add_row(op_add,    32'h0,         32'h0,         16'h0000, 5'd3, 5'd1, 1'b0, 2'd3);
      add_row(op_mov,    32'h0,         32'h0,         16'hC001, 5'd3, 5'd1, 1'b0, 2'd3);
      add_row(op_xor,    32'h0,         32'h0,         16'h0000, 5'd3, 5'd1, 1'b0, 2'd3);
      add_row(op_mov,    32'h0,         32'h0000_0000, 16'hC001, 5'd0, 5'd0, 1'b1, 2'd1);
      // Flush the pipe
      add_row(op_or,     32'h0000_0000, 32'h0000_0000, 16'h0000, 5'd0, 5'd0, 1'b1, 2'd0);
      add_row(op_or,     32'h0000_0000, 32'h0000_0000, 16'h0000, 5'd0, 5'd0, 1'b1, 2'd0);
      add_row(op_or,     32'h0000_0000, 32'h0000_0000, 16'h0000, 5'd0, 5'd0, 1'b1, 2'd0);
   endtask

   // Cycle limit from table length
   always @(posedge gclk) begin
      if (!grst) begin
         cyc_cnt <= cyc_cnt + 1;
         if (cyc_cnt >= rows.size() + 32) begin
            $display("Timeout: table not finished after %0d cycles", cyc_cnt);
            $display("Done: errors found");
            $fatal(1, "timeout");
         end
      end
   end

   initial begin
      row_t cur;
      row_t prev;
      grst = 1'b1;
      dena = 1'b0;
      opc  = op_or;
      rega = '0;
      regb = '0;
      regd = '0;
      imm  = '0;
      rd   = '0;
      ra   = '0;
      build_table();
      prev.en = 1'b0;   // Idle inputs seen after reset
      repeat (8) @(posedge gclk);
      grst <= 1'b0;
      @(negedge gclk);
      check_outputs();   // All zero after reset
      for (int i = 0; i < rows.size(); i++) begin
         @(posedge gclk);
         model_step(prev);   // DUT just took the previous row
         cur = rows[i];
         if (cur.rnd[0]) cur.a = draw_word();
         if (cur.rnd[1]) cur.b = draw_word();
         dena <= cur.en;
         opc  <= cur.opc;
         rega <= cur.a;
         regb <= cur.b;
         regd <= ~cur.a;   // Store data, not observed here
         imm  <= cur.imm;
         rd   <= cur.rd;
         ra   <= cur.ra;
         prev = cur;
         @(negedge gclk);   // Outputs settled
         check_outputs();
      end
      $display("Done: no errors");
      $finish;
   end

endmodule

`default_nettype wire
